// ==== hw/csrPkg.sv ====
`default_nettype none

package csrPkg;

    typedef logic [31:0] csrData_t;
    typedef logic [13:0] csrAddr_t;

    // csr numbers
    localparam csrAddr_t AddrCrmd   = 14'h0;
    localparam csrAddr_t AddrPrmd   = 14'h1;
    localparam csrAddr_t AddrEcfg   = 14'h4;
    localparam csrAddr_t AddrEstat  = 14'h5;
    localparam csrAddr_t AddrEra    = 14'h6;
    localparam csrAddr_t AddrBadv   = 14'h7;
    localparam csrAddr_t AddrEentry = 14'hc;
    localparam csrAddr_t AddrSave0  = 14'h30;
    localparam csrAddr_t AddrTcfg   = 14'h41;
    localparam csrAddr_t AddrTval   = 14'h42;
    localparam csrAddr_t AddrTiclr  = 14'h44;

    // bit 6 is the subcode, bits 5..0 the code
    localparam logic [6:0] ExcInt  = 7'h00;
    localparam logic [6:0] ExcAdef = 7'h08;
    localparam logic [6:0] ExcAle  = 7'h09;
    localparam logic [6:0] ExcSys  = 7'h0b;
    localparam logic [6:0] ExcBrk  = 7'h0c;
    localparam logic [6:0] ExcIne  = 7'h0d;

    typedef struct packed {
        logic [22:0] rsvd;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_s;

    typedef struct packed {
        logic [28:0] upper;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_s;

    typedef struct packed {
        logic [29:0] initVal;
        logic        periodic;
        logic        en;
    } tcfg_s;

    // only the software interrupt bits of an estat write matter
    typedef struct packed {
        logic [29:0] ignored;
        logic [1:0]  swIs;
    } estatSw_s;

    typedef union packed {
        csrData_t raw;
        crmd_s    crmd;
        prmd_s    prmd;
        tcfg_s    tcfg;
        estatSw_s estat;
    } csrWord_u;

    typedef struct packed {
        logic     en;
        csrAddr_t addr;
        csrWord_u data;
    } csrWrite_s;

    typedef struct packed {
        logic       valid;
        logic       isReturn;
        csrData_t   pc;
        csrData_t   addr;
        logic [6:0] excType;
    } trapEvent_s;

    // estat bits 30..16
    typedef struct packed {
        logic [8:0] subCode;
        logic [5:0] code;
    } excCode_s;

    typedef logic [12:0] intrBits_t;

endpackage

`default_nettype wire

// ==== hw/trapState.sv ====
`timescale 1ns/1ps
`default_nettype none

module trapState
    import csrPkg::*;
(
    input  wire        Clk,
    input  wire        rst,
    input  wire        trapEvent_s trapEvt,
    input  wire        csrWrite_s wr,
    output crmd_s      crmd,
    output prmd_s      prmd,
    output csrData_t   era,
    output csrData_t   badv,
    output csrData_t   eentry,
    output excCode_s   excCode
);

    localparam crmd_s CrmdReset = '{da: 1'b1, default: '0};

    logic trapEnter;
    logic trapReturn;

    assign trapEnter  = trapEvt.valid && !trapEvt.isReturn;
    assign trapReturn = trapEvt.valid && trapEvt.isReturn;

    always_ff @(posedge Clk) begin
        if (rst) begin
            crmd <= CrmdReset;
        end else if (trapEnter) begin
            crmd.plv <= 2'd0;
            crmd.ie  <= 1'b0;
        end else if (trapReturn) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (wr.en && wr.addr == AddrCrmd) begin
            crmd <= wr.data.crmd;
        end
    end

    // ertn also blocks a same-cycle prmd write
    always_ff @(posedge Clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (trapEvt.valid) begin
            if (!trapEvt.isReturn) begin
                prmd.pplv <= crmd.plv;
                prmd.pie  <= crmd.ie;
            end
        end else if (wr.en && wr.addr == AddrPrmd) begin
            prmd <= wr.data.prmd;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            era     <= '0;
            badv    <= '0;
            eentry  <= '0;
            excCode <= '0;
        end else begin
            if (trapEnter) begin
                era             <= trapEvt.pc;
                excCode.code    <= trapEvt.excType[5:0];
                excCode.subCode <= {8'd0, trapEvt.excType[6]};
            end
            // software wins on era
            if (wr.en && wr.addr == AddrEra) begin
                era <= wr.data.raw;
            end
            if (wr.en && wr.addr == AddrBadv) begin
                badv <= wr.data.raw;
            end
            // trap capture wins on badv
            if (trapEnter && trapEvt.excType == ExcAdef) begin
                badv <= trapEvt.pc;
            end else if (trapEnter && trapEvt.excType == ExcAle) begin
                badv <= trapEvt.addr;
            end
            if (wr.en && wr.addr == AddrEentry) begin
                eentry <= wr.data.raw;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/intrCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module intrCtrl
    import csrPkg::*;
(
    input  wire       Clk,
    input  wire       rst,
    input  wire       csrWrite_s wr,
    input  wire [7:0] SocInterrupt,
    input  wire       timerHit,
    input  wire       ie,
    output csrData_t  ecfg,
    output intrBits_t pending,
    output logic      EndowInterrupt
);

    logic [1:0] swIs;
    logic [7:0] socIs;
    logic       timerIs;
    logic       ticlrHit;

    assign ticlrHit = wr.en && wr.addr == AddrTiclr && wr.data.raw[0];

    always_ff @(posedge Clk) begin
        if (rst) begin
            ecfg    <= '0;
            swIs    <= '0;
            socIs   <= '0;
            timerIs <= 1'b0;
        end else begin
            // soc lines show up one cycle late
            socIs <= SocInterrupt;
            if (wr.en && wr.addr == AddrEcfg) begin
                ecfg <= wr.data.raw;
            end
            if (wr.en && wr.addr == AddrEstat) begin
                swIs <= wr.data.estat.swIs;
            end
            if (ticlrHit) begin
                timerIs <= 1'b0;
            end
            // set beats clear
            if (timerHit) begin
                timerIs <= 1'b1;
            end
        end
    end

    assign pending = {1'b0, timerIs, 1'b0, socIs, swIs};

    // bit 10 has no enable
    assign EndowInterrupt = ie &&
        (|({ecfg[12:11], ecfg[9:0]} & {pending[12:11], pending[9:0]}));

endmodule

`default_nettype wire

// ==== hw/stableTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stableTimer
    import csrPkg::*;
(
    input  wire      Clk,
    input  wire      rst,
    input  wire      csrWrite_s wr,
    output tcfg_s    tcfg,
    output csrData_t tval,
    output logic     timerHit
);

    always_ff @(posedge Clk) begin
        if (rst) begin
            tcfg <= '0;
        end else if (wr.en && wr.addr == AddrTcfg) begin
            tcfg <= wr.data.tcfg;
        end
    end

    // a tval write overrides the countdown
    always_ff @(posedge Clk) begin
        if (rst) begin
            tval <= '0;
        end else if (wr.en && wr.addr == AddrTval) begin
            tval <= wr.data.raw;
        end else if (tcfg.en) begin
            if (tval != '0) begin
                tval <= tval - 32'd1;
            end else if (tcfg.periodic) begin
                tval <= {tcfg.initVal, 2'b00};
            end else begin
                tval <= '1;
            end
        end
    end

    assign timerHit = tcfg.en && (tval == '0);

endmodule

`default_nettype wire

// ==== hw/scratchRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratchRegs
    import csrPkg::*;
#(
    parameter int NumSave = 4
) (
    input  wire      Clk,
    input  wire      rst,
    input  wire      csrWrite_s wr,
    output csrData_t saveRegs [NumSave]
);

    // slot n answers at AddrSave0 + n
    always_ff @(posedge Clk) begin
        for (int i = 0; i < NumSave; i++) begin
            if (rst) begin
                saveRegs[i] <= '0;
            end else if (wr.en && wr.addr == AddrSave0 + csrAddr_t'(i)) begin
                saveRegs[i] <= wr.data.raw;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/csrReadMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrReadMux
    import csrPkg::*;
#(
    parameter int NumSave = 4
) (
    input  wire       REn,
    input  wire       csrAddr_t RAddr,
    input  wire       crmd_s crmd,
    input  wire       prmd_s prmd,
    input  wire       csrData_t era,
    input  wire       csrData_t badv,
    input  wire       csrData_t eentry,
    input  wire       excCode_s excCode,
    input  wire       csrData_t ecfg,
    input  wire       intrBits_t pending,
    input  wire       tcfg_s tcfg,
    input  wire       csrData_t tval,
    input  wire       csrData_t saveRegs [NumSave],
    output csrData_t  RDate
);

    csrWord_u rdWord;

    always_comb begin
        rdWord.raw = '0;
        case (RAddr)
            AddrCrmd:   rdWord.crmd = crmd;
            AddrPrmd:   rdWord.prmd = prmd;
            AddrEcfg:   rdWord.raw  = ecfg;
            // pending in 12..0, code and subcode in 30..16
            AddrEstat:  rdWord.raw  = {1'b0, excCode, 3'b000, pending};
            AddrEra:    rdWord.raw  = era;
            AddrBadv:   rdWord.raw  = badv;
            AddrEentry: rdWord.raw  = eentry;
            AddrTcfg:   rdWord.tcfg = tcfg;
            AddrTval:   rdWord.raw  = tval;
            default: begin
                for (int i = 0; i < NumSave; i++) begin
                    if (RAddr == AddrSave0 + csrAddr_t'(i)) begin
                        rdWord.raw = saveRegs[i];
                    end
                end
            end
        endcase
    end

    assign RDate = REn ? rdWord.raw : '0;

endmodule

`default_nettype wire

// ==== hw/csrTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrTop
    import csrPkg::*;
#(
    parameter int NumSave = 4
) (
    input  wire             Clk,
    input  wire             rst,
    input  wire             Interrupt,
    input  wire csrData_t   InterruptPc,
    input  wire csrData_t   InterruptAddr,
    input  wire [6:0]       InterruptType,
    input  wire             TrapEntry,
    input  wire [7:0]       SocInterrupt,
    input  wire             WEn,
    input  wire csrAddr_t   WAddr,
    input  wire csrData_t   WDate,
    input  wire             REn,
    input  wire csrAddr_t   RAddr,
    output csrData_t        RDate,
    output logic            EndowInterrupt
);

    trapEvent_s trapEvt;
    csrWrite_s  wr;
    crmd_s      crmd;
    prmd_s      prmd;
    csrData_t   era;
    csrData_t   badv;
    csrData_t   eentry;
    excCode_s   excCode;
    csrData_t   ecfg;
    intrBits_t  pending;
    tcfg_s      tcfg;
    csrData_t   tval;
    logic       timerHit;
    csrData_t   saveRegs [NumSave];

    assign trapEvt.valid    = Interrupt;
    assign trapEvt.isReturn = TrapEntry;
    assign trapEvt.pc       = InterruptPc;
    assign trapEvt.addr     = InterruptAddr;
    assign trapEvt.excType  = InterruptType;

    assign wr.en       = WEn;
    assign wr.addr     = WAddr;
    assign wr.data.raw = WDate;

    trapState i_trapState (
        .Clk(Clk), .rst(rst), .trapEvt(trapEvt), .wr(wr),
        .crmd(crmd), .prmd(prmd), .era(era), .badv(badv),
        .eentry(eentry), .excCode(excCode)
    );

    intrCtrl i_intrCtrl (
        .Clk(Clk), .rst(rst), .wr(wr), .SocInterrupt(SocInterrupt),
        .timerHit(timerHit), .ie(crmd.ie), .ecfg(ecfg), .pending(pending),
        .EndowInterrupt(EndowInterrupt)
    );

    stableTimer i_stableTimer (
        .Clk(Clk), .rst(rst), .wr(wr), .tcfg(tcfg), .tval(tval), .timerHit(timerHit)
    );

    scratchRegs #(.NumSave(NumSave)) i_scratchRegs (
        .Clk(Clk), .rst(rst), .wr(wr), .saveRegs(saveRegs)
    );

    csrReadMux #(.NumSave(NumSave)) i_csrReadMux (
        .REn(REn), .RAddr(RAddr), .crmd(crmd), .prmd(prmd), .era(era),
        .badv(badv), .eentry(eentry), .excCode(excCode), .ecfg(ecfg),
        .pending(pending), .tcfg(tcfg), .tval(tval), .saveRegs(saveRegs),
        .RDate(RDate)
    );

endmodule

`default_nettype wire

// ==== verif/csrTop_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrTopChecker
    import csrPkg::*;
(
    input wire           Clk,
    input wire           rst,
    input wire           REn,
    input wire csrData_t RDate,
    input wire           EndowInterrupt,
    input wire crmd_s    crmd
);

    // read port stays quiet when not enabled
    readIdle: assert property (@(posedge Clk) !REn |-> RDate == '0)
        else $error("RDate is nonzero while REn is low");

    endowNeedsIe: assert property (@(posedge Clk) disable iff (rst)
        EndowInterrupt |-> crmd.ie)
        else $error("EndowInterrupt is high while CRMD IE is clear");

    endowQuietAfterReset: assert property (@(posedge Clk) rst |=> !EndowInterrupt)
        else $error("EndowInterrupt is high right after reset");

endmodule

bind csrTop csrTopChecker i_csrTopChecker (
    .Clk(Clk), .rst(rst), .REn(REn), .RDate(RDate),
    .EndowInterrupt(EndowInterrupt), .crmd(crmd)
);

`default_nettype wire

// ==== verif/csrTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrTb;

    localparam int NumSave = 4;

    logic        Clk;
    logic        rst;
    logic        Interrupt;
    logic [31:0] InterruptPc;
    logic [31:0] InterruptAddr;
    logic [6:0]  InterruptType;
    logic        TrapEntry;
    logic [7:0]  SocInterrupt;
    logic        WEn;
    logic [13:0] WAddr;
    logic [31:0] WDate;
    logic        REn;
    logic [13:0] RAddr;
    logic [31:0] RDate;
    logic        EndowInterrupt;

    byte         opQ [$];
    logic [31:0] addrQ [$];
    logic [31:0] dataQ [$];
    logic [31:0] expQ [$];
    logic [31:0] saveCopy [NumSave];
    int          totalCycles = 0;
    int          checkCount = 0;
    int          errCount = 0;
    logic        casesLoaded = 1'b0;

    csrTop #(.NumSave(NumSave)) i_csrTop (
        .Clk(Clk), .rst(rst), .Interrupt(Interrupt), .InterruptPc(InterruptPc),
        .InterruptAddr(InterruptAddr), .InterruptType(InterruptType),
        .TrapEntry(TrapEntry), .SocInterrupt(SocInterrupt), .WEn(WEn),
        .WAddr(WAddr), .WDate(WDate), .REn(REn), .RAddr(RAddr),
        .RDate(RDate), .EndowInterrupt(EndowInterrupt)
    );

    always #5 Clk = ~Clk;

    // SocInterrupt is a level and is left alone here
    task automatic clearStrobes();
        Interrupt = 1'b0;
        TrapEntry = 1'b0;
        WEn       = 1'b0;
        REn       = 1'b0;
    endtask

    task automatic checkWord(input string what, input logic [31:0] got,
                             input logic [31:0] expVal);
        checkCount++;
        if (got !== expVal) begin
            errCount++;
            $display("ERROR %0t: %s gave %08h, expected %08h", $time, what, got, expVal);
        end
    endtask

    task automatic applyOp(input byte op, input logic [31:0] a, input logic [31:0] d,
                           input logic [31:0] e);
        logic        isSave;
        int          slot;
        logic [31:0] wrData;
        logic [31:0] expVal;
        isSave = (a >= 32'h30) && (a < 32'h30 + 32'(NumSave));
        slot   = int'(a - 32'h30);
        if (op == "N") begin
            repeat (d) begin
                @(negedge Clk);
                clearStrobes();
            end
        end else begin
            @(negedge Clk);
            clearStrobes();
            case (op)
                "W": begin
                    wrData = d;
                    // scratch slots get random data, remembered for the read back
                    if (isSave) begin
                        wrData = $urandom();
                        saveCopy[slot] = wrData;
                    end
                    WEn   = 1'b1;
                    WAddr = a[13:0];
                    WDate = wrData;
                end
                "R": begin
                    expVal = e;
                    if (isSave) begin
                        expVal = saveCopy[slot];
                    end
                    REn   = 1'b1;
                    RAddr = a[13:0];
                    #4;
                    checkWord($sformatf("read of csr %0h", a), RDate, expVal);
                end
                "T": begin
                    Interrupt     = 1'b1;
                    TrapEntry     = 1'b0;
                    InterruptType = a[6:0];
                    InterruptPc   = d;
                    InterruptAddr = e;
                end
                "E": begin
                    Interrupt = 1'b1;
                    TrapEntry = 1'b1;
                end
                "S": SocInterrupt = d[7:0];
                "I": begin
                    #4;
                    checkWord("EndowInterrupt", {31'd0, EndowInterrupt}, e);
                end
                default: begin
                    errCount++;
                    $display("unknown operation %c in the cases file", op);
                end
            endcase
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        void'($urandom(32'h2221));
        Clk           = 1'b0;
        rst           = 1'b1;
        InterruptPc   = '0;
        InterruptAddr = '0;
        InterruptType = '0;
        SocInterrupt  = '0;
        WAddr         = '0;
        WDate         = '0;
        RAddr         = '0;
        clearStrobes();
        fd = $fopen("verif/csr_cases.txt", "r");
        if (fd == 0) begin
            errCount++;
            $display("could not open the cases file verif/csr_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h", op, a, d, e);
                    if (n == 4) begin
                        opQ.push_back(op);
                        addrQ.push_back(a);
                        dataQ.push_back(d);
                        expQ.push_back(e);
                        totalCycles += (op == "N") ? int'(d) : 1;
                    end
                end
            end
            $fclose(fd);
        end
        casesLoaded = 1'b1;
        repeat (10) @(negedge Clk);
        rst = 1'b0;
        foreach (opQ[i]) begin
            applyOp(opQ[i], addrQ[i], dataQ[i], expQ[i]);
        end
        @(negedge Clk);
        clearStrobes();
        $display("checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the cycles listed in the cases file
    initial begin
        wait (casesLoaded);
        repeat (20 * totalCycles + 1000) @(posedge Clk);
        $display("timeout: the run did not end within %0d cycles", 20 * totalCycles + 1000);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/csr_cases.txt ====
# op addr data expected, all hex; T uses addr as type, data as pc, expected as fault addr
# N waits data cycles, S drives SocInterrupt, I checks EndowInterrupt; SAVE data is random
R 0 0 8
R 5 0 0
R 42 0 0
W 30 0 0
W 33 0 0
R 30 0 0
R 33 0 0
W 4 804 0
R 4 0 804
W c 1c008000 0
R c 0 1c008000
R 20 0 0
W 0 f 0
T 9 1c000100 0badf00d
R 0 0 8
R 1 0 7
R 6 0 1c000100
R 7 0 0badf00d
R 5 0 90000
T b 1c000200 12345678
R 7 0 0badf00d
R 5 0 b0000
W 1 7 0
E 0 0 0
R 0 0 f
S 0 1 0
N 0 1 0
I 0 0 1
R 5 0 b0004
W 0 8 0
I 0 0 0
S 0 0 0
W 4 801 0
W 0 c 0
W 5 1 0
I 0 0 1
W 5 0 0
W 41 193 0
W 42 5 0
N 0 8 0
R 5 0 b0800
R 42 0 18d
I 0 0 1
W 44 1 0
N 0 32 0
R 5 0 b0000
I 0 0 0

// ==== sources.f ====
hw/csrPkg.sv
hw/trapState.sv
hw/intrCtrl.sv
hw/stableTimer.sv
hw/scratchRegs.sv
hw/csrReadMux.sv
hw/csrTop.sv
verif/csrTop_checker.sv
verif/csrTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module csrTb -f sources.f -o csrSim
./obj_dir/csrSim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
